/* run_sim.sh */
#!/bin/sh
# build and run the sigmoid stream testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sigmoid_stream -f sources.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_sigmoid_stream > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qx "TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sources.f */
src/sigmoid_pkg.sv
src/input_stage.sv
src/issue_control.sv
src/sigmoid_core.sv
src/output_fifo.sv
src/sigmoid_stream_top.sv
tb/tb_sigmoid_stream.sv

/* src/input_stage.sv */
`timescale 1ns/10ps

module input_stage (
  input  logic                    clk,
  input  logic                    reset,

  // upstream handshake
  input  logic                    data_in_valid,
  input  sigmoid_pkg::fx_t        data_in,
  output logic                    data_in_ready,

  // slot removal strobe from issue control
  input  logic                    issue,
  output sigmoid_pkg::pipe_item_t held
);

  // slot contents
  logic             slot_valid;
  sigmoid_pkg::fx_t slot_value;

  // upstream transfer this cycle
  logic             in_xfer;

  // ####################
  // handshake
  // ####################

  // free slot, or the slot drains this cycle
  assign data_in_ready = !slot_valid || issue;
  assign in_xfer       = data_in_valid && data_in_ready;

  // ####################
  // slot register
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= 1'b0;
    end else if (in_xfer) begin
      // refill, also covers issue plus refill in one cycle
      slot_valid <= 1'b1;
    end else if (issue) begin
      slot_valid <= 1'b0;
    end
    // payload only moves on a transfer
    if (in_xfer) begin
      slot_value <= data_in;
    end
  end

  assign held = '{valid: slot_valid, value: slot_value};

  // issue comes from another block and must only take a full slot
  a_issue_needs_data: assert property (
    @(posedge clk) disable iff (reset) issue |-> slot_valid
  ) else $error("issue while input slot empty");

endmodule

/* src/issue_control.sv */
`timescale 1ns/10ps

module issue_control #(
  parameter int MIN_ISSUE_GAP = 1,
  parameter int OUT_DEPTH     = 4
) (
  input  logic                    clk,
  input  logic                    reset,

  // buffered sample
  input  sigmoid_pkg::pipe_item_t held,

  // downstream handshake, watched to return credits
  input  logic                    data_out_valid,
  input  logic                    data_out_ready,

  // one-cycle start into the core
  output logic                    issue
);

  // counter widths
  localparam int CRED_W = $clog2(OUT_DEPTH + 1);
  localparam int GAP_W  = $clog2(MIN_ISSUE_GAP + 1);

  // free output slots not yet claimed
  logic [CRED_W-1:0] credits;
  // cycles left before the next issue may go
  logic [GAP_W-1:0]  gap_cnt;
  // one result leaves the fifo
  logic              out_xfer;

  assign out_xfer = data_out_valid && data_out_ready;

  // ####################
  // issue decision
  // ####################

  // every issued item owns a fifo slot, so the core never stalls
  assign issue = held.valid && (credits != '0) && (gap_cnt == '0);

  // ####################
  // credit counter
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CRED_W'(OUT_DEPTH);
    end else begin
      case ({issue, out_xfer})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        // spend and return cancel out
        default: credits <= credits;
      endcase
    end
  end

  // ####################
  // forced initiation interval
  // ####################

  // countdown reloads on issue, holds issue off until zero
  always_ff @(posedge clk) begin
    if (reset) begin
      gap_cnt <= '0;
    end else if (issue) begin
      gap_cnt <= GAP_W'(MIN_ISSUE_GAP - 1);
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  // more returns than issues would mean a lost or doubled output
  a_credit_max: assert property (
    @(posedge clk) disable iff (reset) credits <= CRED_W'(OUT_DEPTH)
  ) else $error("credit count above fifo depth");

  // from empty the count may only stay or grow by one
  a_credit_underflow: assert property (
    @(posedge clk) disable iff (reset) (credits == '0) |=> (credits <= CRED_W'(1))
  ) else $error("credit count wrapped below zero");

endmodule

/* src/output_fifo.sv */
`timescale 1ns/10ps

module output_fifo #(
  // slots, at least 2
  parameter int OUT_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    reset,

  // write side from the core
  input  sigmoid_pkg::pipe_item_t result,

  // downstream handshake
  output logic                    data_out_valid,
  output sigmoid_pkg::fx_t        data_out,
  input  logic                    data_out_ready
);

  localparam int PTR_W = $clog2(OUT_DEPTH);
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);

  // storage
  sigmoid_pkg::fx_t mem [OUT_DEPTH];

  // circular pointers and fill level
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic wr_en;
  logic rd_en;
  logic full;

  assign wr_en = result.valid;
  assign rd_en = data_out_valid && data_out_ready;
  assign full  = (count == CNT_W'(OUT_DEPTH));

  // head of queue, registered so a write shows next cycle
  assign data_out_valid = (count != '0);
  assign data_out       = mem[rd_ptr];

  // ####################
  // pointers and count
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap by compare, depth need not be a power of two
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // data write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= result.value;
    end
  end

  // credit accounting upstream keeps a slot free for every result
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) wr_en |-> !full
  ) else $error("result written into full fifo");

  // stalled output holds its value
  a_stable_stall: assert property (
    @(posedge clk) disable iff (reset)
    (data_out_valid && !data_out_ready) |=> (data_out_valid && $stable(data_out))
  ) else $error("data_out changed while stalled");

endmodule

/* src/sigmoid_core.sv */
`timescale 1ns/10ps

module sigmoid_core #(
  // total pipeline depth of at least 2
  parameter int LATENCY = 3
) (
  input  logic                    clk,
  input  logic                    reset,

  // start strobe and the sample it takes
  input  logic                    issue,
  input  sigmoid_pkg::pipe_item_t held,

  // valid pulses LATENCY cycles after issue
  output sigmoid_pkg::pipe_item_t result
);

  // stages after the first with the clamp stage at index 0
  localparam int NUM_TAIL = LATENCY - 1;

  // floor of x/4 widened so the offset cannot wrap
  logic signed [16:0] shifted;

  // stage one holds the shifted sample plus one half
  logic               s1_valid;
  logic signed [16:0] s1_sum;

  // clamp stage and delay line
  logic [NUM_TAIL-1:0] tail_valid;
  sigmoid_pkg::fx_t    tail_value [NUM_TAIL];

  // sign-extended before the arithmetic shift
  assign shifted = held.value >>> 2;

  // ####################
  // pipeline registers
  // ####################

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid   <= 1'b0;
      tail_valid <= '0;
    end else begin
      s1_valid      <= issue;
      tail_valid[0] <= s1_valid;
      for (int i = 1; i < NUM_TAIL; i++) begin
        tail_valid[i] <= tail_valid[i-1];
      end
    end

    // stage one adds one half
    s1_sum <= shifted + 17'(sigmoid_pkg::FX_HALF);

    // stage two clamps to 0..1
    if (s1_sum < 0) begin
      tail_value[0] <= '0;
    end else if (s1_sum > 17'(sigmoid_pkg::FX_ONE)) begin
      tail_value[0] <= sigmoid_pkg::FX_ONE;
    end else begin
      tail_value[0] <= sigmoid_pkg::fx_t'(s1_sum[15:0]);
    end

    // plain delay for the remaining stages
    for (int i = 1; i < NUM_TAIL; i++) begin
      tail_value[i] <= tail_value[i-1];
    end
  end

  assign result = '{valid: tail_valid[NUM_TAIL-1], value: tail_value[NUM_TAIL-1]};

endmodule

/* src/sigmoid_pkg.sv */
package sigmoid_pkg;

  // ####################
  // fixed-point format
  // ####################

  // q6.10 signed sample
  typedef logic signed [15:0] fx_t;

  // fraction bits of fx_t
  localparam int FX_FRAC_BITS = 10;

  // one in q6.10
  localparam fx_t FX_ONE = fx_t'(1 << FX_FRAC_BITS);

  // one half in q6.10
  localparam fx_t FX_HALF = fx_t'(1 << (FX_FRAC_BITS - 1));

  // ####################
  // stage-to-stage item
  // ####################

  // sample plus its valid flag, 17 bits
  typedef struct packed {
    logic valid;
    fx_t  value;
  } pipe_item_t;

  // ####################
  // default parameters
  // ####################

  // core pipeline depth in cycles
  localparam int DEFAULT_LATENCY = 3;

  // cycles between two issues to the core
  localparam int DEFAULT_MIN_ISSUE_GAP = 1;

  // result slots in the output buffer
  localparam int DEFAULT_OUT_DEPTH = 4;

endpackage

/* src/sigmoid_stream_top.sv */
`timescale 1ns/10ps

module sigmoid_stream_top #(
  // core latency, at least 2
  parameter int LATENCY       = sigmoid_pkg::DEFAULT_LATENCY,
  // minimum issue spacing, at least 1
  parameter int MIN_ISSUE_GAP = sigmoid_pkg::DEFAULT_MIN_ISSUE_GAP,
  // output fifo slots, at least 2
  parameter int OUT_DEPTH     = sigmoid_pkg::DEFAULT_OUT_DEPTH
) (
  input  logic              clk,
  input  logic              reset,

  input  logic              data_in_valid,
  input  sigmoid_pkg::fx_t  data_in,
  output logic              data_in_ready,

  output logic              data_out_valid,
  output sigmoid_pkg::fx_t  data_out,
  input  logic              data_out_ready
);

  // sample waiting for issue
  sigmoid_pkg::pipe_item_t held;
  // core output, valid is a one-cycle strobe
  sigmoid_pkg::pipe_item_t result;
  // start strobe into the core
  logic                    issue;

  // ####################
  // input buffer
  // ####################

  input_stage u_input_stage (
    .clk           (clk),
    .reset         (reset),
    .data_in_valid (data_in_valid),
    .data_in       (data_in),
    .data_in_ready (data_in_ready),
    .issue         (issue),
    .held          (held)
  );

  // credits and forced initiation interval
  issue_control #(
    .MIN_ISSUE_GAP (MIN_ISSUE_GAP),
    .OUT_DEPTH     (OUT_DEPTH)
  ) u_issue_control (
    .clk            (clk),
    .reset          (reset),
    .held           (held),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready),
    .issue          (issue)
  );

  // ####################
  // compute and output
  // ####################

  sigmoid_core #(
    .LATENCY (LATENCY)
  ) u_sigmoid_core (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .held   (held),
    .result (result)
  );

  output_fifo #(
    .OUT_DEPTH (OUT_DEPTH)
  ) u_output_fifo (
    .clk            (clk),
    .reset          (reset),
    .result         (result),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

endmodule

/* tb/sigmoid_golden.hex */
// columns: input sample, expected output, both q6.10 in hex
// expected is floor(input / 4) + 0x200, clamped to 0x000..0x400
0000 0200
0400 0300
FC00 0100
0200 0280
FE00 0180
0100 0240
FF01 01C0
0123 0248
FEDD 01B7
0800 0400
F800 0000
0C00 0400
F400 0000
0801 0400
F7FF 0000
07FF 03FF
F805 0001
F801 0000
7FFF 0400
8000 0000
FFFF 01FF
FFFD 01FF
FFFB 01FE
0003 0200
0005 0201

/* tb/tb_sigmoid_stream.sv */
`timescale 1ns/10ps

module tb_sigmoid_stream;

  localparam int LATENCY       = 3;
  localparam int MIN_ISSUE_GAP = 2;
  localparam int OUT_DEPTH     = 4;

  // vectors in the golden file
  localparam int NUM_VEC = 25;
  localparam int SEED    = 90391;

  // cycle limits, one per kind of wait
  localparam int STREAM_TIMEOUT = 2000;
  localparam int STALL_TIMEOUT  = 80;
  // low cycles in a row that mean the input side has really stalled
  localparam int QUIET_CYCLES   = 8;

  // downstream ready patterns
  localparam int MODE_RANDOM = 0;
  localparam int MODE_FULL   = 1;
  localparam int MODE_STALL  = 2;

  logic             clk;
  logic             reset;
  logic             data_in_valid;
  sigmoid_pkg::fx_t data_in;
  logic             data_in_ready;
  logic             data_out_valid;
  sigmoid_pkg::fx_t data_out;
  logic             data_out_ready;

  // input and expected words, interleaved as in the file
  logic [15:0]      golden [2*NUM_VEC];
  sigmoid_pkg::fx_t stim [NUM_VEC];
  sigmoid_pkg::fx_t expected_val [NUM_VEC];

  int check_count;
  int error_count;
  int output_count;

  sigmoid_stream_top #(
    .LATENCY       (LATENCY),
    .MIN_ISSUE_GAP (MIN_ISSUE_GAP),
    .OUT_DEPTH     (OUT_DEPTH)
  ) dut (
    .clk            (clk),
    .reset          (reset),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ####################
  // helpers
  // ####################

  task automatic check_value(input string name, input int actual, input int expected);
    check_count++;
    if (actual != expected) begin
      error_count++;
      $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, actual, expected);
    end
  endtask

  // streams all vectors once, observes each edge, then drives the next cycle
  task automatic run_stream(input int mode);
    int  sent;
    int  got;
    int  cycles;
    int  last_out;
    int  quiet;
    int  extra;
    bit  stall_done;
    bit  prev_stall;
    bit  hold;
    sigmoid_pkg::fx_t prev_out;

    sent       = 0;
    got        = 0;
    cycles     = 0;
    last_out   = 0;
    quiet      = 0;
    extra      = 0;
    stall_done = (mode != MODE_STALL);
    prev_stall = 1'b0;
    prev_out   = '0;
    data_out_ready <= (mode == MODE_FULL);

    while (got < NUM_VEC && cycles < STREAM_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (data_in_valid && data_in_ready) begin
        sent++;
      end
      // stalled output must hold
      if (prev_stall) begin
        check_value("data_out_valid", int'(data_out_valid), 1);
        check_value("data_out", int'(data_out), int'(prev_out));
      end
      if (data_out_valid && data_out_ready) begin
        check_value("data_out", int'(data_out), int'(expected_val[got]));
        if (mode == MODE_FULL && got > 0 && cycles - last_out < MIN_ISSUE_GAP) begin
          error_count++;
          $display("output transfers only %0d cycles apart at %0t ns, minimum is %0d",
                   cycles - last_out, $time, MIN_ISSUE_GAP);
        end
        last_out = cycles;
        got++;
        output_count++;
      end
      prev_stall = data_out_valid && !data_out_ready;
      prev_out   = data_out;

      // back-pressure phase, input side should settle low
      if (!stall_done) begin
        if (data_in_ready) begin
          quiet = 0;
        end else begin
          quiet++;
        end
        if (quiet >= QUIET_CYCLES) begin
          // fifo slots plus the input slot
          check_value("accepted_inputs", sent, OUT_DEPTH + 1);
          stall_done = 1'b1;
        end else if (cycles >= STALL_TIMEOUT) begin
          error_count++;
          $display("data_in_ready did not stay low within %0d cycles of output stall",
                   STALL_TIMEOUT);
          stall_done = 1'b1;
        end
      end

      // source holds valid and data until taken
      hold = data_in_valid && !data_in_ready;
      if (!hold) begin
        if (sent < NUM_VEC && (mode != MODE_RANDOM || $urandom_range(3, 0) != 0)) begin
          data_in_valid <= 1'b1;
          data_in       <= stim[sent];
        end else begin
          data_in_valid <= 1'b0;
        end
      end

      case (mode)
        MODE_RANDOM: data_out_ready <= ($urandom_range(2, 0) != 0);
        MODE_FULL:   data_out_ready <= 1'b1;
        default:     data_out_ready <= stall_done;
      endcase
    end

    if (got < NUM_VEC) begin
      error_count++;
      $display("timeout after %0d cycles, only %0d of %0d outputs arrived",
               cycles, got, NUM_VEC);
    end

    // no duplicate may follow the last result
    data_in_valid  <= 1'b0;
    data_out_ready <= 1'b1;
    repeat (LATENCY + 4) begin
      @(posedge clk);
      if (data_out_valid) begin
        extra++;
      end
    end
    check_value("extra_outputs", extra, 0);
  endtask

  // ####################
  // main sequence
  // ####################

  initial begin
    void'($urandom(SEED));
    check_count    = 0;
    error_count    = 0;
    output_count   = 0;
    reset          = 1'b1;
    data_in_valid  = 1'b0;
    data_in        = '0;
    data_out_ready = 1'b0;

    $readmemh("tb/sigmoid_golden.hex", golden);
    for (int i = 0; i < NUM_VEC; i++) begin
      stim[i]         = golden[2*i];
      expected_val[i] = golden[2*i+1];
    end

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // idle state straight after reset
    @(posedge clk);
    check_value("data_out_valid", int'(data_out_valid), 0);
    check_value("data_in_ready", int'(data_in_ready), 1);

    run_stream(MODE_RANDOM);
    run_stream(MODE_FULL);
    run_stream(MODE_STALL);

    $display("checks %0d, errors %0d, outputs %0d of %0d",
             check_count, error_count, output_count, 3 * NUM_VEC);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
